/* sim.f */
src/msdapPkg.sv
src/wordLoader.sv
src/sharedStore.sv
src/filterEngine.sv
src/serialOutput.sv
src/msdapTop.sv
tests/msdapTop_assertions.sv
tests/msdapTb.sv

/* run.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module msdapTb -f sim.f -o msdapSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/msdapSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Result: FAILED" "$logFile"; then
	echo "Testbench reported a failure"
	exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

/* tests/msdapTb.sv */
`timescale 1ns/100ps

module msdapTb;

	localparam int sleepLimit = 6;
	localparam int period = 20;
	localparam int burstBits = 40;
	localparam int rowCount = 32;
	// Cycle budget per table row
	localparam int rowCycles = 700;
	localparam int watchdogCycles = rowCount * rowCycles + 20000;

	typedef struct packed {
		logic restart;
		logic cfgB;
		logic randomize;
		msdapPkg::dataWord value;
	} stimRow;

	logic sClk;
	logic reset;
	logic start;
	msdapPkg::dataWord wordIn;
	logic wordStrobe;
	logic inReady;
	logic outReady;
	logic serialOut;
	logic sleepMode;

	stimRow stimTable [rowCount];
	logic [15:0] rjTab [16];
	logic [15:0] coefTab [512];
	logic signed [15:0] hist [$];
	logic [39:0] expQueue [$];
	logic [39:0] gotWord;
	logic [39:0] expWord;
	logic modelSleep;
	int seed;
	int zeroRun;
	int stimErrors;
	int monErrors;
	int expCount;
	int wordsSeen;
	int bitIdx;

	msdapTop #(
		.sleepLimit(sleepLimit)
	) dut0 (
		.sClk(sClk),
		.reset(reset),
		.start(start),
		.wordIn(wordIn),
		.wordStrobe(wordStrobe),
		.inReady(inReady),
		.outReady(outReady),
		.serialOut(serialOut),
		.sleepMode(sleepMode)
	);

	bind msdapTop msdapAssertions assert0 (
		.sClk(sClk),
		.reset(reset),
		.inReady(inReady),
		.outReady(outReady),
		.sleepMode(sleepMode),
		.sampleTaken(sampleTaken)
	);

	initial
	begin
		sClk = 1'b0;
		forever #(period / 2) sClk = ~sClk;
	end

	//////////////////////////////
	// Configurations and model
	//////////////////////////////

	function automatic logic [15:0] rjFor(logic cfgB, int k);
		if (!cfgB)
			return 16'd32;
		// Some groups are empty in B
		if (k % 4 == 1)
			return 16'd0;
		return 16'(k * 3 + 7);
	endfunction

	function automatic logic [15:0] coefFor(logic cfgB, int i);
		logic [7:0] delay;
		logic sign;
		if (!cfgB)
		begin
			delay = 8'(i / 2);
			sign = (i % 3 == 1);
		end
		else
		begin
			delay = 8'((i * 37 + 5) % 256);
			sign = (i % 5 < 2);
		end
		return {7'b0, sign, delay};
	endfunction

	// Grouped sum with a halving after every group
	function automatic logic [39:0] modelOutput();
		longint acc;
		longint groupSum;
		longint term;
		int idx;
		int n;
		int pos;
		logic [15:0] c;
		acc = 0;
		idx = 0;
		n = hist.size() - 1;
		for (int k = 0; k < 16; k++)
		begin
			groupSum = 0;
			for (int j = 0; j < int'(rjTab[k]); j++)
			begin
				c = coefTab[idx];
				idx++;
				pos = n - int'(c[7:0]);
				if (pos >= 0)
				begin
					term = longint'(hist[pos]) * 65536;
					if (c[8])
						groupSum = groupSum - term;
					else
						groupSum = groupSum + term;
				end
			end
			acc = (acc + groupSum) >>> 1;
		end
		return acc[39:0];
	endfunction

	function automatic stimRow makeRow(logic restart, logic cfgB, logic randomize,
		msdapPkg::dataWord value);
		return {restart, cfgB, randomize, value};
	endfunction

	task automatic buildTable();
		// Impulse, then zeros
		stimTable[0] = makeRow(1'b1, 1'b0, 1'b0, 16'h0001);
		for (int i = 1; i <= 4; i++)
			stimTable[i] = makeRow(1'b0, 1'b0, 1'b0, 16'h0000);
		for (int i = 5; i <= 12; i++)
			stimTable[i] = makeRow(1'b0, 1'b0, 1'b1, 16'h0000);
		// Zero run long enough to reach sleep
		for (int i = 13; i <= 20; i++)
			stimTable[i] = makeRow(1'b0, 1'b0, 1'b0, 16'h0000);
		stimTable[21] = makeRow(1'b0, 1'b0, 1'b0, 16'h7a31);
		for (int i = 22; i <= 25; i++)
			stimTable[i] = makeRow(1'b0, 1'b0, 1'b1, 16'h0000);
		stimTable[26] = makeRow(1'b1, 1'b1, 1'b1, 16'h0000);
		for (int i = 27; i < rowCount; i++)
			stimTable[i] = makeRow(1'b0, 1'b1, 1'b1, 16'h0000);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	// Called 2 ns after a rising edge, returns at the same offset
	task automatic sendWord(msdapPkg::dataWord value);
		while (inReady !== 1'b1)
		begin
			@(posedge sClk);
			#2;
		end
		wordIn = value;
		wordStrobe = 1'b1;
		@(posedge sClk);
		#2;
		wordStrobe = 1'b0;
	endtask

	task automatic restartAndLoad(logic cfgB);
		while (expQueue.size() != 0 || outReady)
		begin
			@(posedge sClk);
			#2;
		end
		start = 1'b1;
		@(posedge sClk);
		#2;
		start = 1'b0;
		if (inReady !== 1'b1)
		begin
			stimErrors++;
			$display("Mismatch at %0t: inReady is %b after start, expected 1", $time, inReady);
		end
		hist.delete();
		zeroRun = 0;
		modelSleep = 1'b0;
		for (int k = 0; k < 16; k++)
		begin
			rjTab[k] = rjFor(cfgB, k);
			sendWord(rjTab[k]);
		end
		for (int i = 0; i < 512; i++)
		begin
			coefTab[i] = coefFor(cfgB, i);
			sendWord(coefTab[i]);
		end
	endtask

	task automatic applySample(msdapPkg::dataWord value);
		logic computed;
		sendWord(value);
		hist.push_back(value);
		if (value == 16'h0000)
		begin
			zeroRun++;
			computed = !(modelSleep || zeroRun == sleepLimit);
			if (zeroRun == sleepLimit)
				modelSleep = 1'b1;
		end
		else
		begin
			zeroRun = 0;
			modelSleep = 1'b0;
			computed = 1'b1;
		end
		if (computed)
		begin
			expQueue.push_back(modelOutput());
			expCount++;
		end
		if (sleepMode !== modelSleep)
		begin
			stimErrors++;
			$display("Mismatch at %0t: sleepMode is %b, expected %b", $time, sleepMode, modelSleep);
		end
	endtask

	initial
	begin
		stimRow row;
		msdapPkg::dataWord value;
		reset = 1'b0;
		start = 1'b0;
		wordIn = '0;
		wordStrobe = 1'b0;
		seed = 32'h262f;
		zeroRun = 0;
		modelSleep = 1'b0;
		stimErrors = 0;
		expCount = 0;
		buildTable();
		repeat (3) @(posedge sClk);
		#2;
		reset = 1'b1;
		// Idle before start
		repeat (4)
		begin
			@(posedge sClk);
			#2;
			if (inReady !== 1'b0 || outReady !== 1'b0 || sleepMode !== 1'b0)
			begin
				stimErrors++;
				$display("Mismatch at %0t: ports %b%b%b before start, expected 000",
					$time, inReady, outReady, sleepMode);
			end
		end
		for (int r = 0; r < rowCount; r++)
		begin
			row = stimTable[r];
			if (row.restart)
				restartAndLoad(row.cfgB);
			value = row.randomize ? 16'($random(seed)) : row.value;
			applySample(value);
		end
		while (expQueue.size() != 0)
		begin
			@(posedge sClk);
			#2;
		end
		// Room for a stray computation to show up
		repeat (rowCycles + 500) @(posedge sClk);
		if (wordsSeen != expCount)
		begin
			stimErrors++;
			$display("Mismatch at %0t: %0d output words, expected %0d", $time, wordsSeen, expCount);
		end
		$display("Errors: %0d stimulus, %0d output; words %0d of %0d",
			stimErrors, monErrors, wordsSeen, expCount);
		if (stimErrors + monErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	//////////////////////////////
	// Output monitor
	//////////////////////////////

	initial
	begin
		monErrors = 0;
		wordsSeen = 0;
		bitIdx = 0;
	end

	always @(negedge sClk)
	begin
		if (outReady === 1'b1)
		begin
			gotWord[bitIdx] = serialOut;
			bitIdx++;
			if (bitIdx == burstBits)
			begin
				bitIdx = 0;
				wordsSeen++;
				if (expQueue.size() == 0)
				begin
					monErrors++;
					$display("Output word %h at %0t arrived with no result expected", gotWord, $time);
				end
				else
				begin
					expWord = expQueue.pop_front();
					if (gotWord !== expWord)
					begin
						monErrors++;
						$display("Mismatch at %0t: output %h, expected %h", $time, gotWord, expWord);
					end
				end
			end
		end
		else if (bitIdx != 0)
		begin
			monErrors++;
			$display("Output burst stopped after %0d bits at %0t", bitIdx, $time);
			bitIdx = 0;
		end
	end

	initial
	begin
		repeat (watchdogCycles) @(posedge sClk);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* tests/msdapTop_assertions.sv */
`timescale 1ns/100ps

module msdapAssertions (
	input logic sClk,
	input logic reset,
	input logic inReady,
	input logic outReady,
	input logic sleepMode,
	input logic sampleTaken
);

	localparam int burstBits = 40;

	// Consecutive high cycles of outReady so far
	logic [5:0] highRun;

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
			highRun <= '0;
		else if (outReady)
			highRun <= highRun + 1'b1;
		else
			highRun <= '0;
	end

	//////////////////////////////
	// Port rules
	//////////////////////////////

	resetQuiet: assert property (@(posedge sClk) !reset |-> (!outReady && !inReady))
		else $error("outReady or inReady high while reset is held");

	// A burst ends after exactly 40 cycles
	burstLength: assert property (@(posedge sClk) disable iff (!reset)
		$fell(outReady) |-> (highRun == 6'(burstBits)))
		else $error("outReady burst ended early");

	burstLimit: assert property (@(posedge sClk) disable iff (!reset)
		outReady |-> (highRun < 6'(burstBits)))
		else $error("outReady burst ran too long");

	// No computation starts in sleep, so a burst then carries an earlier result
	sleepQuiet: assert property (@(posedge sClk) disable iff (!reset)
		sleepMode |-> !sampleTaken)
		else $error("a sample was taken for computation during sleep");

endmodule

/* src/msdapTop.sv */
`timescale 1ns/100ps

module msdapTop #(
	parameter int sleepLimit = 800
) (
	input  logic              sClk,
	input  logic              reset,
	input  logic              start,
	input  msdapPkg::dataWord wordIn,
	input  logic              wordStrobe,
	output logic              inReady,
	output logic              outReady,
	output logic              serialOut,
	output logic              sleepMode
);

	msdapPkg::memRequest writeReq;
	msdapPkg::memRequest readReq;
	logic                readGrant;
	msdapPkg::dataWord   readData;

	// Sample hand-off between loader and engine
	logic samplePending;
	logic sampleTaken;
	logic sampleStored;

	// Result hand-off between engine and shifter
	logic                resultValid;
	msdapPkg::accumWord  result;
	logic                resultTaken;

	wordLoader #(
		.sleepLimit(sleepLimit)
	) loader0 (
		.sClk(sClk),
		.reset(reset),
		.start(start),
		.wordIn(wordIn),
		.wordStrobe(wordStrobe),
		.inReady(inReady),
		.writeReq(writeReq),
		.samplePending(samplePending),
		.sampleTaken(sampleTaken),
		.sampleStored(sampleStored),
		.sleepMode(sleepMode)
	);

	sharedStore store0 (
		.sClk(sClk),
		.writeReq(writeReq),
		.readReq(readReq),
		.readGrant(readGrant),
		.readData(readData)
	);

	filterEngine engine0 (
		.sClk(sClk),
		.reset(reset),
		.start(start),
		.samplePending(samplePending),
		.sampleStored(sampleStored),
		.sampleTaken(sampleTaken),
		.readReq(readReq),
		.readGrant(readGrant),
		.readData(readData),
		.resultValid(resultValid),
		.result(result),
		.resultTaken(resultTaken)
	);

	serialOutput output0 (
		.sClk(sClk),
		.reset(reset),
		.resultValid(resultValid),
		.result(result),
		.resultTaken(resultTaken),
		.serialOut(serialOut),
		.outReady(outReady)
	);

endmodule

/* src/serialOutput.sv */
`timescale 1ns/100ps

module serialOutput (
	input  logic               sClk,
	input  logic               reset,
	input  logic               resultValid,
	input  msdapPkg::accumWord result,
	output logic               resultTaken,
	output logic               serialOut,
	output logic               outReady
);

	localparam int countBits = $clog2(msdapPkg::accWidth);

	logic                 busy;
	logic [countBits-1:0] bitCount;
	msdapPkg::accumWord   shiftReg;

	// Capture only from idle, so bursts are always separated
	assign resultTaken = resultValid && !busy;
	assign outReady = busy;
	assign serialOut = shiftReg[0];

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			busy <= 1'b0;
			bitCount <= '0;
		end
		else if (resultTaken)
		begin
			busy <= 1'b1;
			bitCount <= '0;
		end
		else if (busy)
		begin
			if (bitCount == countBits'(msdapPkg::accWidth - 1))
				busy <= 1'b0;
			bitCount <= bitCount + 1'b1;
		end
	end

	// LSB first
	always_ff @(posedge sClk)
	begin
		if (resultTaken)
			shiftReg <= result;
		else if (busy)
			shiftReg <= shiftReg >> 1;
	end

endmodule

/* src/filterEngine.sv */
`timescale 1ns/100ps

module filterEngine (
	input  logic                sClk,
	input  logic                reset,
	input  logic                start,
	input  logic                samplePending,
	input  logic                sampleStored,
	output logic                sampleTaken,
	output msdapPkg::memRequest readReq,
	input  logic                readGrant,
	input  msdapPkg::dataWord   readData,
	output logic                resultValid,
	output msdapPkg::accumWord  result,
	input  logic                resultTaken
);

	typedef enum logic [3:0] {
		idle, reqRj, waitRj, reqCoef, waitCoef, reqX, waitX, groupEnd, done
	} engineState;

	localparam int rjBits = $clog2(msdapPkg::rjCount);
	localparam int coefBits = $clog2(msdapPkg::coefCount);
	localparam int groupBits = $clog2(msdapPkg::coefCount + 1);
	localparam int sampleBits = $clog2(msdapPkg::sampleDepth);

	engineState            state;
	logic [rjBits-1:0]     rjIdx;
	logic [coefBits-1:0]   coefPtr;
	logic [groupBits-1:0]  groupLeft;
	logic [sampleBits-1:0] storedCount;
	logic [sampleBits-1:0] curCount;
	logic                  pastDelay;
	logic                  curFull;
	logic [7:0]            delay;
	logic                  subtract;
	logic [sampleBits-1:0] sampleOff;
	logic                  inRange;
	logic                  lastTerm;
	msdapPkg::accumWord    acc;
	msdapPkg::accumWord    term;

	assign sampleTaken = (state == idle) && samplePending;
	assign resultValid = (state == done);
	assign result = acc;

	// Sample n lives at n modulo the region size
	assign sampleOff = curCount - 1'b1 - sampleBits'(delay);
	// Index below zero reads as zero and is skipped
	assign inRange = curFull || (sampleBits'(readData[7:0]) < curCount);
	assign lastTerm = (groupLeft == groupBits'(1));
	assign term = {{8{readData[15]}}, readData, 16'h0000};

	always_comb
	begin
		readReq = '0;
		case (state)
			reqRj:
			begin
				readReq.valid = 1'b1;
				readReq.addr = msdapPkg::storeAddr'(msdapPkg::rjBase)
					+ msdapPkg::storeAddr'(rjIdx);
			end
			reqCoef:
			begin
				readReq.valid = 1'b1;
				readReq.addr = msdapPkg::storeAddr'(msdapPkg::coefBase)
					+ msdapPkg::storeAddr'(coefPtr);
			end
			reqX:
			begin
				readReq.valid = 1'b1;
				readReq.addr = msdapPkg::storeAddr'(msdapPkg::sampleBase)
					+ msdapPkg::storeAddr'(sampleOff);
			end
			default: ;
		endcase
	end

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			state <= idle;
			rjIdx <= '0;
			coefPtr <= '0;
			groupLeft <= '0;
			storedCount <= '0;
			curCount <= '0;
			pastDelay <= 1'b0;
			curFull <= 1'b0;
		end
		else if (start)
		begin
			// Sample index starts over
			state <= idle;
			rjIdx <= '0;
			coefPtr <= '0;
			groupLeft <= '0;
			storedCount <= '0;
			curCount <= '0;
			pastDelay <= 1'b0;
			curFull <= 1'b0;
		end
		else
		begin
			if (sampleStored)
			begin
				storedCount <= storedCount + 1'b1;
				// From here on every delay lands on a real sample
				if (storedCount == sampleBits'(255))
					pastDelay <= 1'b1;
			end
			case (state)
				idle:
				begin
					if (samplePending)
					begin
						state <= reqRj;
						rjIdx <= '0;
						coefPtr <= '0;
						curCount <= storedCount;
						curFull <= pastDelay;
					end
				end
				reqRj:    if (readGrant) state <= waitRj;
				waitRj:
				begin
					groupLeft <= readData[groupBits-1:0];
					state <= (readData[groupBits-1:0] == '0) ? groupEnd : reqCoef;
				end
				reqCoef:
				begin
					if (readGrant)
					begin
						state <= waitCoef;
						coefPtr <= coefPtr + 1'b1;
					end
				end
				waitCoef:
				begin
					if (inRange)
						state <= reqX;
					else
					begin
						groupLeft <= groupLeft - 1'b1;
						state <= lastTerm ? groupEnd : reqCoef;
					end
				end
				reqX:     if (readGrant) state <= waitX;
				waitX:
				begin
					groupLeft <= groupLeft - 1'b1;
					state <= lastTerm ? groupEnd : reqCoef;
				end
				groupEnd:
				begin
					rjIdx <= rjIdx + 1'b1;
					state <= (rjIdx == rjBits'(msdapPkg::rjCount - 1)) ? done : reqRj;
				end
				done:     if (resultTaken) state <= idle;
				default:  state <= idle;
			endcase
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	always_ff @(posedge sClk)
	begin
		case (state)
			idle:     if (samplePending) acc <= '0;
			waitCoef:
			begin
				delay <= readData[7:0];
				subtract <= readData[8];
			end
			waitX:    acc <= subtract ? acc - term : acc + term;
			// Group sum is already in, halve with sign
			groupEnd: acc <= acc >>> 1;
			default: ;
		endcase
	end

endmodule

/* src/sharedStore.sv */
`timescale 1ns/100ps

module sharedStore (
	input  logic                sClk,
	input  msdapPkg::memRequest writeReq,
	input  msdapPkg::memRequest readReq,
	output logic                readGrant,
	output msdapPkg::dataWord   readData
);

	//////////////////////////////
	// Layout
	//////////////////////////////

	// rj words, then coefficients, then the circular sample region
	localparam int depth = msdapPkg::sampleBase + msdapPkg::sampleDepth;

	msdapPkg::dataWord mem [depth];

	//////////////////////////////
	// Arbiter
	//////////////////////////////

	// Loader writes have fixed priority
	// The engine holds its read until a cycle without a write
	assign readGrant = readReq.valid && !writeReq.valid;

	//////////////////////////////
	// Array
	//////////////////////////////

	always_ff @(posedge sClk)
	begin
		if (writeReq.valid)
			mem[writeReq.addr] <= writeReq.data;
	end

	// Read data arrives the cycle after the grant
	always_ff @(posedge sClk)
	begin
		if (readGrant)
			readData <= mem[readReq.addr];
	end

endmodule

/* src/wordLoader.sv */
`timescale 1ns/100ps

module wordLoader #(
	parameter int sleepLimit = 800
) (
	input  logic                sClk,
	input  logic                reset,
	input  logic                start,
	input  msdapPkg::dataWord   wordIn,
	input  logic                wordStrobe,
	output logic                inReady,
	output msdapPkg::memRequest writeReq,
	output logic                samplePending,
	input  logic                sampleTaken,
	output logic                sampleStored,
	output logic                sleepMode
);

	typedef enum logic [1:0] {idle, loadRj, loadCoef, sample} loadPhase;

	// One counter serves rj, coefficient and sample positions
	localparam int countBits = $clog2(msdapPkg::sampleDepth);
	localparam int runBits = $clog2(sleepLimit + 1);

	loadPhase             phase;
	logic [countBits-1:0] wordCount;
	logic [runBits-1:0]   zeroRun;
	logic                 sampleWrite;
	logic                 computeWrite;
	logic                 accept;
	logic                 isZero;
	logic                 reachLimit;
	msdapPkg::storeAddr   base;

	assign accept = wordStrobe && inReady;
	assign isZero = (wordIn == '0);
	assign reachLimit = isZero && (zeroRun + 1'b1 == runBits'(sleepLimit));

	// Busy during the write cycle and while a sample waits for the engine
	assign inReady = (phase != idle) && !writeReq.valid && !samplePending;
	assign sampleStored = writeReq.valid && sampleWrite;

	always_comb
	begin
		case (phase)
			loadRj:   base = msdapPkg::storeAddr'(msdapPkg::rjBase);
			loadCoef: base = msdapPkg::storeAddr'(msdapPkg::coefBase);
			default:  base = msdapPkg::storeAddr'(msdapPkg::sampleBase);
		endcase
	end

	always_ff @(posedge sClk or negedge reset)
	begin
		if (!reset)
		begin
			phase <= idle;
			wordCount <= '0;
			zeroRun <= '0;
			sleepMode <= 1'b0;
			samplePending <= 1'b0;
			sampleWrite <= 1'b0;
			computeWrite <= 1'b0;
			writeReq <= '0;
		end
		else if (start)
		begin
			phase <= loadRj;
			wordCount <= '0;
			zeroRun <= '0;
			sleepMode <= 1'b0;
			samplePending <= 1'b0;
			sampleWrite <= 1'b0;
			computeWrite <= 1'b0;
			writeReq <= '0;
		end
		else
		begin
			writeReq.valid <= accept;
			sampleWrite <= accept && (phase == sample);
			if (sampleTaken)
				samplePending <= 1'b0;
			// Pending rises once the sample is in the store
			if (sampleStored && computeWrite)
				samplePending <= 1'b1;
			if (accept)
			begin
				writeReq.addr <= base + msdapPkg::storeAddr'(wordCount);
				writeReq.data <= wordIn;
				case (phase)
					loadRj:
					begin
						if (wordCount == countBits'(msdapPkg::rjCount - 1))
						begin
							phase <= loadCoef;
							wordCount <= '0;
						end
						else
							wordCount <= wordCount + 1'b1;
					end
					loadCoef:
					begin
						if (wordCount == countBits'(msdapPkg::coefCount - 1))
						begin
							phase <= sample;
							wordCount <= '0;
						end
						else
							wordCount <= wordCount + 1'b1;
					end
					sample:
					begin
						// Write pointer wraps over the sample region
						wordCount <= wordCount + 1'b1;
						computeWrite <= !(isZero && (sleepMode || reachLimit));
						if (!isZero)
						begin
							zeroRun <= '0;
							sleepMode <= 1'b0;
						end
						else
						begin
							if (zeroRun != runBits'(sleepLimit))
								zeroRun <= zeroRun + 1'b1;
							if (reachLimit)
								sleepMode <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

/* src/msdapPkg.sv */
package msdapPkg;

	//////////////////////////////
	// Word and accumulator widths
	//////////////////////////////

	localparam int wordWidth = 16;
	localparam int accWidth = 40;

	// Table sizes
	localparam int rjCount = 16;
	localparam int coefCount = 512;

	// Circular sample region, larger than the 255 maximum delay
	localparam int sampleDepth = 512;

	//////////////////////////////
	// Store layout
	//////////////////////////////

	localparam int addrWidth = 11;

	// Region starts inside the shared store
	localparam int rjBase = 0;
	localparam int coefBase = 16;
	localparam int sampleBase = 528;

	typedef logic [addrWidth-1:0] storeAddr;

	typedef logic [wordWidth-1:0] dataWord;

	// Filter accumulator and output word
	typedef logic signed [accWidth-1:0] accumWord;

	// Store request, a write from the loader or a read from the engine
	typedef struct packed {
		logic valid;
		storeAddr addr;
		dataWord data;
	} memRequest;

endpackage
